//--- logic/tinker_macros.svh
/*
 * Tinker core constants
 * Widths, reset values, memory size and the nop encoding
 */

`ifndef TINKER_MACROS_SVH
`define TINKER_MACROS_SVH

// Datapath widths
`define XLEN 64
`define ILEN 32
`define ADDR_W 32

// Reset values
`define PC_RESET 64'h0000_0000_0000_2000 // First fetch address
`define SP_RESET 64'h0000_0000_0008_0000 // Stack pointer in r31

// Unified byte memory
`define MEM_BYTES 65536

// Halt-class opcode with literal 1, so decode treats it as an empty slot
`define NOP_WORD 32'h7800_0001

`endif

//--- logic/tinker_pkg.sv
/*
 * Tinker core types
 * Opcode encoding and the payloads passed between pipeline stages
 */

`include "tinker_macros.svh"

package tinker_pkg;

    // Kept opcodes in their Tinker encodings
    typedef enum logic [4:0] {
        OP_AND    = 5'h00,
        OP_OR     = 5'h01,
        OP_XOR    = 5'h02,
        OP_NOT    = 5'h03,
        OP_SHFTR  = 5'h04,
        OP_SHFTRI = 5'h05,
        OP_SHFTL  = 5'h06,
        OP_SHFTLI = 5'h07,
        OP_PRIV   = 5'h0F, // Halt with literal 0, nop otherwise
        OP_LOAD   = 5'h10,
        OP_MOV_RR = 5'h11,
        OP_MOV_L  = 5'h12,
        OP_STORE  = 5'h13,
        OP_ADD    = 5'h18,
        OP_ADDI   = 5'h19,
        OP_SUB    = 5'h1A,
        OP_SUBI   = 5'h1B,
        OP_MUL    = 5'h1C
    } opcode_e;

    // Instruction word split into fields
    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [11:0] lit;
    } instr_t;

    // Decode to execute
    typedef struct packed {
        logic              valid;
        opcode_e           opcode;
        logic [4:0]        rd;
        logic [`XLEN-1:0]  pc;
        logic [`XLEN-1:0]  operand1; // Value of rs
        logic [`XLEN-1:0]  operand2; // Value of rt or sign-extended literal
        logic [`XLEN-1:0]  rd_val;   // Old value of rd
    } decoded_t;

    // Execute to memory and result
    typedef struct packed {
        logic               valid;
        logic [4:0]         rd;
        logic               reg_wr;
        logic               is_load;
        logic               is_store;
        logic [`ADDR_W-1:0] addr;
        logic [`XLEN-1:0]   store_data;
        logic [`XLEN-1:0]   alu_result;
    } mem_req_t;

    // Register write as seen on the core output
    typedef struct packed {
        logic             valid;
        logic [4:0]       rd;
        logic [`XLEN-1:0] data;
    } wb_t;

    // Program load request
    typedef struct packed {
        logic               strobe;
        logic [`ADDR_W-1:0] addr;
        logic [`ILEN-1:0]   word;
    } load_t;

endpackage

//--- logic/tinker_fetch.sv
/*
 * Tinker fetch stage
 * Program counter with start and halt gating, feeding the fetch/decode register
 */

`timescale 1ns/1ps
`include "tinker_macros.svh"

module tinker_fetch import tinker_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  logic             halt,
    output logic [`XLEN-1:0] fetch_addr,
    input  logic [`ILEN-1:0] instr_word,
    output instr_t           if_instr,
    output logic [`XLEN-1:0] if_pc,
    output logic             if_valid
);

    logic [`XLEN-1:0] pc;
    logic             run;

    assign run        = start && !halt; // Stops for good once decode halts
    assign fetch_addr = pc;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc       <= `PC_RESET;
            if_valid <= 1'b0;
        end else begin
            if (!start) pc <= `PC_RESET;
            else if (run) pc <= pc + `XLEN'd4;
            if_valid <= run;
        end
    end

    // Squashed slots carry the nop word
    always_ff @(posedge clk) begin
        if_instr <= run ? instr_t'(instr_word) : instr_t'(`NOP_WORD);
        if_pc    <= pc;
    end

endmodule

//--- logic/tinker_regfile.sv
/*
 * Tinker register file
 * 32 x 64-bit registers, three combinational reads and one write
 */

`timescale 1ns/1ps
`include "tinker_macros.svh"

module tinker_regfile import tinker_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic [4:0]       rs_addr,
    input  logic [4:0]       rt_addr,
    input  logic [4:0]       rd_addr,
    output logic [`XLEN-1:0] rs_val,
    output logic [`XLEN-1:0] rt_val,
    output logic [`XLEN-1:0] rd_val,
    input  wb_t              wr
);

    logic [`XLEN-1:0] regs [32];

    // ------------------------------------------------
    // Read ports
    // ------------------------------------------------
    assign rs_val = regs[rs_addr];
    assign rt_val = regs[rt_addr];
    assign rd_val = regs[rd_addr]; // Used by mov rd,L and store

    // ------------------------------------------------
    // Write port
    // ------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 31; i++) begin
                regs[i] <= '0;
            end
            regs[31] <= `SP_RESET; // Stack pointer
        end else if (wr.valid) begin
            regs[wr.rd] <= wr.data;
        end
    end

endmodule

//--- logic/tinker_decode.sv
/*
 * Tinker decode stage
 * Field split, operand selection and halt detection,
 * feeding the decode/execute register
 */

`timescale 1ns/1ps
`include "tinker_macros.svh"

module tinker_decode import tinker_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  instr_t           if_instr,
    input  logic [`XLEN-1:0] if_pc,
    input  logic             if_valid,
    output logic [4:0]       rs_addr,
    output logic [4:0]       rt_addr,
    output logic [4:0]       rd_addr,
    input  logic [`XLEN-1:0] rs_val,
    input  logic [`XLEN-1:0] rt_val,
    input  logic [`XLEN-1:0] rd_val,
    output logic             halt,
    output decoded_t         dec
);

    logic             uses_lit;
    logic [`XLEN-1:0] lit_sext;
    logic             halt_now;
    logic             halt_q;
    decoded_t         dec_d;

    assign rs_addr = if_instr.rs;
    assign rt_addr = if_instr.rt;
    assign rd_addr = if_instr.rd;

    // Forms that take the literal in place of rt
    assign uses_lit = if_instr.opcode inside {OP_ADDI, OP_SUBI, OP_SHFTRI, OP_SHFTLI,
                                              OP_MOV_L, OP_LOAD, OP_STORE};
    assign lit_sext = {{(`XLEN-12){if_instr.lit[11]}}, if_instr.lit};

    // ------------------------------------------------
    // Sticky halt
    // ------------------------------------------------
    assign halt_now = if_valid && (if_instr.opcode == OP_PRIV) && (if_instr.lit == 12'h000);
    assign halt     = halt_now || halt_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) halt_q <= 1'b0;
        else if (halt_now) halt_q <= 1'b1;
    end

    // ------------------------------------------------
    // Decode/execute register
    // ------------------------------------------------
    always_comb begin
        dec_d.valid    = if_valid;
        dec_d.opcode   = if_instr.opcode;
        dec_d.rd       = if_instr.rd;
        dec_d.pc       = if_pc;
        dec_d.operand1 = rs_val;
        dec_d.operand2 = uses_lit ? lit_sext : rt_val;
        dec_d.rd_val   = rd_val;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) dec.valid <= 1'b0;
        else dec <= dec_d;
    end

endmodule

//--- logic/tinker_execute.sv
/*
 * Tinker execute stage
 * Integer ALU and address forming, feeding the execute/memory register
 */

`timescale 1ns/1ps
`include "tinker_macros.svh"

module tinker_execute import tinker_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  decoded_t dec,
    output mem_req_t req
);

    logic [`XLEN-1:0] result;
    logic [`XLEN-1:0] eff_addr;
    logic             reg_wr;
    logic             is_load;
    logic             is_store;
    mem_req_t         req_d;

    // ------------------------------------------------
    // ALU
    // ------------------------------------------------
    always_comb begin
        result   = '0;
        eff_addr = '0;
        reg_wr   = 1'b1;
        is_load  = 1'b0;
        is_store = 1'b0;
        case (dec.opcode)
            OP_ADD, OP_ADDI:     result = dec.operand1 + dec.operand2;
            OP_SUB, OP_SUBI:     result = dec.operand1 - dec.operand2;
            OP_MUL:              result = dec.operand1 * dec.operand2;
            OP_AND:              result = dec.operand1 & dec.operand2;
            OP_OR:               result = dec.operand1 | dec.operand2;
            OP_XOR:              result = dec.operand1 ^ dec.operand2;
            OP_NOT:              result = ~dec.operand1;
            OP_SHFTR, OP_SHFTRI: result = dec.operand1 >> dec.operand2;
            OP_SHFTL, OP_SHFTLI: result = dec.operand1 << dec.operand2;
            OP_MOV_RR:           result = dec.operand1;
            OP_MOV_L: begin
                // Literal lands in the top 12 bits, rest of rd kept
                result = {dec.operand2[11:0], dec.rd_val[`XLEN-13:0]};
            end
            OP_LOAD: begin
                eff_addr = dec.operand1 + dec.operand2; // rs + L
                is_load  = 1'b1;
            end
            OP_STORE: begin
                eff_addr = dec.rd_val + dec.operand2;   // rd + L
                reg_wr   = 1'b0;
                is_store = 1'b1;
            end
            default: reg_wr = 1'b0; // Nop, halt and dropped opcodes
        endcase
    end

    // ------------------------------------------------
    // Execute/memory register
    // ------------------------------------------------
    always_comb begin
        req_d.valid      = dec.valid;
        req_d.rd         = dec.rd;
        req_d.reg_wr     = reg_wr;
        req_d.is_load    = is_load;
        req_d.is_store   = is_store;
        req_d.addr       = eff_addr[`ADDR_W-1:0];
        req_d.store_data = dec.operand1;
        req_d.alu_result = result;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) req.valid <= 1'b0;
        else req <= req_d;
    end

endmodule

//--- logic/tinker_memory.sv
/*
 * Tinker unified memory
 * Byte array with fetch and data reads, data store and program load
 */

`timescale 1ns/1ps
`include "tinker_macros.svh"

module tinker_memory import tinker_pkg::*; (
    input  logic             clk,
    input  logic [`XLEN-1:0] fetch_addr,
    output logic [`ILEN-1:0] instr_word,
    input  mem_req_t         req,
    output logic [`XLEN-1:0] load_data,
    input  load_t            load
);

    localparam int MEM_AW = $clog2(`MEM_BYTES);

    logic [7:0]        mem [`MEM_BYTES];
    logic [MEM_AW-1:0] fetch_base;
    logic [MEM_AW-1:0] data_base;
    logic [MEM_AW-1:0] load_base;

    // Addresses wrap at the memory size
    assign fetch_base = fetch_addr[MEM_AW-1:0];
    assign data_base  = req.addr[MEM_AW-1:0];
    assign load_base  = load.addr[MEM_AW-1:0];

    // ------------------------------------------------
    // Combinational reads, little-endian
    // ------------------------------------------------
    always_comb begin
        for (int i = 0; i < `ILEN/8; i++) begin
            instr_word[8*i +: 8] = mem[fetch_base + MEM_AW'(i)];
        end
    end

    always_comb begin
        for (int i = 0; i < `XLEN/8; i++) begin
            load_data[8*i +: 8] = mem[data_base + MEM_AW'(i)];
        end
    end

    // ------------------------------------------------
    // Writes, program load first
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (load.strobe) begin
            for (int i = 0; i < `ILEN/8; i++) begin
                mem[load_base + MEM_AW'(i)] <= load.word[8*i +: 8];
            end
        end else if (req.valid && req.is_store) begin
            for (int i = 0; i < `XLEN/8; i++) begin
                mem[data_base + MEM_AW'(i)] <= req.store_data[8*i +: 8];
            end
        end
    end

endmodule

//--- logic/tinker_result.sv
/*
 * Tinker result stage
 * Memory/result register and write-back source select
 */

`timescale 1ns/1ps
`include "tinker_macros.svh"

module tinker_result import tinker_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  mem_req_t         req,
    input  logic [`XLEN-1:0] load_data,
    output wb_t              wb
);

    wb_t wb_d;

    always_comb begin
        wb_d.valid = req.valid && req.reg_wr; // Stores and nops write nothing
        wb_d.rd    = req.rd;
        wb_d.data  = req.is_load ? load_data : req.alu_result;
    end

    // One-cycle pulse per register write
    always_ff @(posedge clk or posedge reset) begin
        if (reset) wb.valid <= 1'b0;
        else wb <= wb_d;
    end

endmodule

//--- logic/tinker_core.sv
/*
 * Tinker five-stage pipeline core
 * Fetch, decode, execute, memory, result; no forwarding or hazard checks
 */

`timescale 1ns/1ps
`include "tinker_macros.svh"

module tinker_core import tinker_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  start,
    input  load_t load,
    output logic  hlt,
    output wb_t   wb
);

    logic [`XLEN-1:0] fetch_addr;
    logic [`ILEN-1:0] instr_word;
    instr_t           if_instr;
    logic [`XLEN-1:0] if_pc;
    logic             if_valid;
    logic [4:0]       rs_addr;
    logic [4:0]       rt_addr;
    logic [4:0]       rd_addr;
    logic [`XLEN-1:0] rs_val;
    logic [`XLEN-1:0] rt_val;
    logic [`XLEN-1:0] rd_val;
    decoded_t         dec;
    mem_req_t         req;
    logic [`XLEN-1:0] load_data;

    // --------------------------------------------------
    // Front end
    // --------------------------------------------------
    tinker_fetch fetch_i (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .halt       (hlt),
        .fetch_addr (fetch_addr),
        .instr_word (instr_word),
        .if_instr   (if_instr),
        .if_pc      (if_pc),
        .if_valid   (if_valid)
    );

    tinker_decode decode_i (
        .clk      (clk),
        .reset    (reset),
        .if_instr (if_instr),
        .if_pc    (if_pc),
        .if_valid (if_valid),
        .rs_addr  (rs_addr),
        .rt_addr  (rt_addr),
        .rd_addr  (rd_addr),
        .rs_val   (rs_val),
        .rt_val   (rt_val),
        .rd_val   (rd_val),
        .halt     (hlt),   // Sticky halt level
        .dec      (dec)
    );

    tinker_regfile regfile_i (
        .clk     (clk),
        .reset   (reset),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rd_addr (rd_addr),
        .rs_val  (rs_val),
        .rt_val  (rt_val),
        .rd_val  (rd_val),
        .wr      (wb)      // Write-back from result stage
    );

    // --------------------------------------------------
    // Back end
    // --------------------------------------------------
    tinker_execute execute_i (
        .clk   (clk),
        .reset (reset),
        .dec   (dec),
        .req   (req)
    );

    tinker_memory memory_i (
        .clk        (clk),
        .fetch_addr (fetch_addr),
        .instr_word (instr_word),
        .req        (req),
        .load_data  (load_data),
        .load       (load)
    );

    tinker_result result_i (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .load_data (load_data),
        .wb        (wb)
    );

endmodule

//--- sim/tinker_core_checker.sv
/*
 * Port-level checks for the Tinker core
 * Sticky halt, known write-back valid and drain after halt
 */

`timescale 1ns/1ps

module tinker_core_checker import tinker_pkg::*; (
    input logic clk,
    input logic reset,
    input logic hlt,
    input wb_t  wb
);

    // --------------------------------------------------
    // Halt
    // --------------------------------------------------
    hlt_held: assert property (@(posedge clk) disable iff (reset) hlt |=> hlt)
        else $error("hlt fell while reset was low");

    // Instructions ahead of the halt have at most four cycles to retire
    no_late_wb: assert property (@(posedge clk) disable iff (reset) hlt |-> ##5 !wb.valid)
        else $error("register write more than four cycles after halt");

    // --------------------------------------------------
    // Write-back
    // --------------------------------------------------
    wb_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(wb.valid))
        else $error("wb.valid is unknown after reset");

endmodule

//--- sim/tinker_core_tb.sv
/*
 * Testbench for the Tinker pipeline core
 * Loads a random program, runs it on an in-order model
 * and compares every register write of the DUT
 */

`timescale 1ns/1ps
`include "tinker_macros.svh"

module tinker_core_tb import tinker_pkg::*; ();

    localparam int RESET_CYCLES = 3;
    localparam int DRAIN_CYCLES = 8; // Covers the four-cycle drain window
    localparam int N_TRAIL      = 4; // Writers placed behind the halt

    logic  clk;
    logic  reset;
    logic  start;
    load_t prog_load;
    logic  hlt;
    wb_t   wb;

    logic [`ILEN-1:0] program_q [$];
    wb_t              expected_q [$];
    logic [`XLEN-1:0] model_regs [32];
    logic [7:0]       model_mem [int];
    logic [63:0]      rng;
    int               value_errors = 0;
    int               other_errors = 0;
    int               watchdog_cycles = 0;
    logic             started = 1'b0;
    logic             hlt_seen = 1'b0;

    tinker_core tinker_core_i (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .load  (prog_load),
        .hlt   (hlt),
        .wb    (wb)
    );

    bind tinker_core tinker_core_checker tinker_core_checker_i (
        .clk   (clk),
        .reset (reset),
        .hlt   (hlt),
        .wb    (wb)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // --------------------------------------------------
    // Program generation and reference model
    // --------------------------------------------------
    function automatic logic [63:0] xorshift(logic [63:0] x);
        logic [63:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 7);
        y = y ^ (y << 17);
        return y;
    endfunction

    function automatic int rand_range(int lo, int hi);
        rng = xorshift(rng);
        return lo + int'(rng % 64'(hi - lo + 1));
    endfunction

    // Fields are opcode, rd, rs, rt, 12-bit literal
    function automatic logic [`ILEN-1:0] encode(opcode_e op, int rd, int rs, int rt, int lit);
        return {op, 5'(rd), 5'(rs), 5'(rt), 12'(lit)};
    endfunction

    task automatic model_exec(opcode_e op, int rd, int rs, int rt, int lit);
        logic [11:0]      lit12;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] lit_s;
        logic [`XLEN-1:0] res;
        logic [`XLEN-1:0] addr;
        logic             writes;
        wb_t              entry;
        lit12  = 12'(lit);
        lit_s  = {{(`XLEN-12){lit12[11]}}, lit12};
        a      = model_regs[rs];
        b      = model_regs[rt];
        res    = '0;
        writes = 1'b1;
        case (op)
            OP_ADD:    res = a + b;
            OP_ADDI:   res = a + lit_s;
            OP_SUB:    res = a - b;
            OP_SUBI:   res = a - lit_s;
            OP_MUL:    res = a * b;
            OP_AND:    res = a & b;
            OP_OR:     res = a | b;
            OP_XOR:    res = a ^ b;
            OP_NOT:    res = ~a;
            OP_SHFTR:  res = a >> b;
            OP_SHFTRI: res = a >> lit_s;
            OP_SHFTL:  res = a << b;
            OP_SHFTLI: res = a << lit_s;
            OP_MOV_RR: res = a;
            OP_MOV_L:  res = {lit12, model_regs[rd][`XLEN-13:0]}; // Upper 12 bits only
            OP_LOAD: begin
                addr = a + lit_s;
                for (int i = 0; i < 8; i++) begin
                    res[8*i +: 8] = model_mem[int'((addr + 64'(i)) % `MEM_BYTES)];
                end
            end
            OP_STORE: begin
                addr   = model_regs[rd] + lit_s;
                writes = 1'b0;
                for (int i = 0; i < 8; i++) begin
                    model_mem[int'((addr + 64'(i)) % `MEM_BYTES)] = a[8*i +: 8];
                end
            end
            default: writes = 1'b0;
        endcase
        if (writes) begin
            model_regs[rd] = res;
            entry.valid    = 1'b1;
            entry.rd       = 5'(rd);
            entry.data     = res;
            expected_q.push_back(entry);
        end
    endtask

    // Three nops keep every consumer four slots behind its producer
    task automatic emit(opcode_e op, int rd, int rs, int rt, int lit);
        program_q.push_back(encode(op, rd, rs, rt, lit));
        model_exec(op, rd, rs, rt, lit);
        repeat (3) program_q.push_back(`NOP_WORD);
    endtask

    task automatic build_program();
        int d;
        int base;
        int off;
        // Random operands in r1 and r2 and a shift amount in r3
        emit(OP_ADDI, 1, 1, 0, rand_range(0, 4095));
        emit(OP_MOV_L, 1, 0, 0, rand_range(0, 4095));
        emit(OP_ADDI, 2, 2, 0, rand_range(0, 4095));
        emit(OP_MOV_L, 2, 0, 0, rand_range(0, 4095));
        emit(OP_ADDI, 3, 3, 0, rand_range(0, 63));
        emit(OP_ADD, rand_range(5, 30), 1, 2, 0);
        emit(OP_SUB, rand_range(5, 30), 1, 2, 0);
        emit(OP_MUL, rand_range(5, 30), 1, 2, 0);
        emit(OP_AND, rand_range(5, 30), 1, 2, 0);
        emit(OP_OR, rand_range(5, 30), 1, 2, 0);
        emit(OP_XOR, rand_range(5, 30), 1, 2, 0);
        emit(OP_NOT, rand_range(5, 30), 1, 0, 0);
        emit(OP_SHFTR, rand_range(5, 30), 1, 3, 0);
        emit(OP_SHFTL, rand_range(5, 30), 2, 3, 0);
        // Literal forms work in place on rd
        d = rand_range(5, 30);
        emit(OP_MOV_RR, d, 1, 0, 0);
        emit(OP_SUBI, d, d, 0, rand_range(0, 4095));
        emit(OP_SHFTRI, d, d, 0, rand_range(0, 63));
        d = rand_range(5, 30);
        emit(OP_MOV_RR, d, 2, 0, 0);
        emit(OP_SHFTLI, d, d, 0, rand_range(0, 63));
        emit(OP_MOV_L, d, 0, 0, rand_range(0, 4095));
        // Store and load back below the program area
        base = 8 * rand_range(16, 255);
        off  = 8 * rand_range(0, 15);
        emit(OP_ADDI, 4, 4, 0, base);
        emit(OP_STORE, 4, 1, 0, off);
        emit(OP_LOAD, rand_range(5, 30), 4, 0, off);
        program_q.push_back(encode(OP_PRIV, 0, 0, 0, 0));
        repeat (N_TRAIL) program_q.push_back(encode(OP_ADDI, 5, 5, 0, 1));
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    task automatic load_program();
        for (int i = 0; i < program_q.size(); i++) begin
            @(negedge clk);
            prog_load.strobe = 1'b1;
            prog_load.addr   = `ADDR_W'(`PC_RESET + 64'(4 * i));
            prog_load.word   = program_q[i];
        end
        @(negedge clk);
        prog_load = '0;
    endtask

    task automatic finish_run();
        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    initial begin
        reset     = 1'b1;
        start     = 1'b0;
        prog_load = '0;
        rng       = 64'd98335;
        for (int i = 0; i < 31; i++) begin
            model_regs[i] = '0;
        end
        model_regs[31] = `SP_RESET;
        build_program();
        watchdog_cycles = 2 * (RESET_CYCLES + 2 * program_q.size() + DRAIN_CYCLES);
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        load_program();
        start   = 1'b1;
        started = 1'b1;
        wait (hlt_seen);
        repeat (DRAIN_CYCLES) @(negedge clk);
        assert (expected_q.size() == 0) else begin
            $display("%0d expected register writes never appeared before the halt",
                     expected_q.size());
            other_errors++;
        end
        finish_run();
    end

    // Checks on hlt and every wb pulse
    always @(negedge clk) begin : monitor
        wb_t front;
        if (!reset) begin
            if (!started) begin
                assert (!hlt && !wb.valid) else begin
                    $display("hlt or wb.valid went high at %0d ns before the program ran", $time);
                    other_errors++;
                end
            end
            if (hlt_seen) begin
                assert (hlt) else begin
                    $display("hlt fell at %0d ns after the core had halted", $time);
                    other_errors++;
                end
            end
            if (hlt) hlt_seen = 1'b1;
            if (wb.valid) begin
                assert (expected_q.size() > 0) else begin
                    $display("Unexpected write to r%0d at %0d ns, no write was left to come",
                             wb.rd, $time);
                    other_errors++;
                end
                if (expected_q.size() > 0) begin
                    front = expected_q.pop_front();
                    assert (wb.rd == front.rd && wb.data === front.data) else begin
                        $display("error at %0d ns: expected r%0d = %h, got r%0d = %h",
                                 $time, front.rd, front.data, wb.rd, wb.data);
                        value_errors++;
                    end
                end
            end
        end
    end

    // --------------------------------------------------
    // Watchdog
    // --------------------------------------------------
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: the core did not halt within %0d cycles", watchdog_cycles);
        other_errors++;
        finish_run();
    end

endmodule

//--- tinker_core.f
+incdir+logic
logic/tinker_pkg.sv
logic/tinker_fetch.sv
logic/tinker_regfile.sv
logic/tinker_decode.sv
logic/tinker_execute.sv
logic/tinker_memory.sv
logic/tinker_result.sv
logic/tinker_core.sv
sim/tinker_core_checker.sv
sim/tinker_core_tb.sv

//--- Bender.yml
package:
  name: tinker_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/tinker_pkg.sv
      - logic/tinker_fetch.sv
      - logic/tinker_regfile.sv
      - logic/tinker_decode.sv
      - logic/tinker_execute.sv
      - logic/tinker_memory.sv
      - logic/tinker_result.sv
      - logic/tinker_core.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/tinker_core_checker.sv
      - sim/tinker_core_tb.sv
